// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= loader_tb
RTL_TOP   ?= loader_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/byte_fifo.sv
// byte FIFO with gray pointers

`include "loader_defs.svh"

module byte_fifo
    import loader_pkg::*;
(
    input  logic  i_clk_rd,
    input  logic  i_rst_n,
    input  logic  i_push,
    input  byte_t i_push_data,
    input  logic  i_pop,
    output byte_t o_rd_data,
    output logic  o_empty,
    output logic  o_full
);

    localparam int AW = `LOADER_FIFO_AW;

    byte_t mem [`LOADER_FIFO_DEPTH];

    logic [AW:0] wr_ptr_bin;
    logic [AW:0] wr_ptr_gray;
    logic [AW:0] rd_ptr_bin;
    logic [AW:0] rd_ptr_gray;
    logic [AW:0] wr_gray_s1;
    logic [AW:0] wr_gray_s2;
    logic [AW:0] rd_gray_s1;
    logic [AW:0] rd_gray_s2;
    logic [AW:0] wr_bin_nxt;
    logic [AW:0] rd_bin_nxt;
    logic        push_ok;

    assign push_ok    = i_push && !o_full;
    assign wr_bin_nxt = wr_ptr_bin + 1'b1;
    assign rd_bin_nxt = rd_ptr_bin + 1'b1;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge i_clk_rd) begin
        if (push_ok) begin
            mem[wr_ptr_bin[AW-1:0]] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk_rd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
            rd_gray_s1  <= '0;
            rd_gray_s2  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_bin  <= wr_bin_nxt;
                wr_ptr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
            rd_gray_s1 <= rd_ptr_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // full when the top two gray bits differ and the rest match
    assign o_full = (wr_ptr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

    // ------------------------------
    // read side
    // ------------------------------
    always_ff @(posedge i_clk_rd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
            wr_gray_s1  <= '0;
            wr_gray_s2  <= '0;
        end else begin
            if (i_pop) begin
                rd_ptr_bin  <= rd_bin_nxt;
                rd_ptr_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
            wr_gray_s1 <= wr_ptr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign o_empty   = (wr_gray_s2 == rd_ptr_gray);
    assign o_rd_data = mem[rd_ptr_bin[AW-1:0]];

    // the consumer must respect empty
    a_no_pop_empty: assert property (@(posedge i_clk_rd) disable iff (!i_rst_n)
        !(i_pop && o_empty));

endmodule

// File: design/loader_defs.svh
// program loader parameters

`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// byte FIFO geometry
`define LOADER_FIFO_DEPTH 16

// pointers carry one extra wrap bit on top of this
`define LOADER_FIFO_AW 4

// program memory, 256 instruction words
`define LOADER_PMEM_AW 8

`endif

// File: design/loader_pkg.sv
// program loader types

package loader_pkg;

    // one byte from the serial receiver
    typedef logic [7:0] byte_t;

    // opcode in the upper byte, operand in the lower byte
    typedef struct packed {
        byte_t opcode;
        byte_t operand;
    } instr_fields_t;

    // instruction word, raw for storage or split into fields
    typedef union packed {
        logic [15:0]   raw;
        instr_fields_t fields;
    } instr_word_u;

endpackage

// File: design/loader_top.sv
// program loader top level

`include "loader_defs.svh"

module loader_top
    import loader_pkg::*;
(
    input  logic                       i_clk_rd,
    input  logic                       i_rst_n,
    input  logic                       i_clk_wr,
    input  logic                       i_valid_uart,
    input  logic [7:0]                 i_data_uart,
    input  logic                       i_load_en,
    input  logic [`LOADER_PMEM_AW-1:0] i_cpu_addr,
    output logic [7:0]                 o_opcode,
    output logic [7:0]                 o_operand,
    output logic [`LOADER_PMEM_AW-1:0] o_load_addr,
    output logic                       o_fifo_empty,
    output logic                       o_fifo_full
);

    logic        byte_valid;
    byte_t       byte_in;
    byte_t       fifo_head;
    logic        pop;
    logic        wr_en;
    instr_word_u wr_word;
    instr_word_u rd_word;

    uart_strobe_sync uart_strobe_sync_i (
        .i_clk_rd     (i_clk_rd),
        .i_rst_n      (i_rst_n),
        .i_clk_wr     (i_clk_wr),
        .i_valid_uart (i_valid_uart),
        .i_data_uart  (i_data_uart),
        .o_byte_valid (byte_valid),
        .o_byte       (byte_in)
    );

    byte_fifo byte_fifo_i (
        .i_clk_rd    (i_clk_rd),
        .i_rst_n     (i_rst_n),
        .i_push      (byte_valid),
        .i_push_data (byte_in),
        .i_pop       (pop),
        .o_rd_data   (fifo_head),
        .o_empty     (o_fifo_empty),
        .o_full      (o_fifo_full)
    );

    // write address doubles as the load progress counter
    word_assembler word_assembler_i (
        .i_clk_rd     (i_clk_rd),
        .i_rst_n      (i_rst_n),
        .i_load_en    (i_load_en),
        .i_fifo_empty (o_fifo_empty),
        .i_fifo_data  (fifo_head),
        .o_pop        (pop),
        .o_wr_en      (wr_en),
        .o_wr_addr    (o_load_addr),
        .o_wr_word    (wr_word)
    );

    program_mem program_mem_i (
        .i_clk_rd  (i_clk_rd),
        .i_wr_en   (wr_en),
        .i_wr_addr (o_load_addr),
        .i_wr_word (wr_word),
        .i_rd_addr (i_cpu_addr),
        .o_rd_word (rd_word)
    );

    assign o_opcode  = rd_word.fields.opcode;
    assign o_operand = rd_word.fields.operand;

endmodule

// File: design/program_mem.sv
// instruction store

`include "loader_defs.svh"

module program_mem
    import loader_pkg::*;
(
    input  logic                       i_clk_rd,
    input  logic                       i_wr_en,
    input  logic [`LOADER_PMEM_AW-1:0] i_wr_addr,
    input  instr_word_u                i_wr_word,
    input  logic [`LOADER_PMEM_AW-1:0] i_rd_addr,
    output instr_word_u                o_rd_word
);

    localparam int WORDS = 2 ** `LOADER_PMEM_AW;

    logic [15:0] mem [WORDS];
    instr_word_u rd_q;

    // loader write port
    always_ff @(posedge i_clk_rd) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_word.raw;
        end
    end

    // cpu read port, one cycle latency
    always_ff @(posedge i_clk_rd) begin
        rd_q.raw <= mem[i_rd_addr];
    end

    assign o_rd_word.fields.opcode  = rd_q.fields.opcode;
    assign o_rd_word.fields.operand = rd_q.fields.operand;

endmodule

// File: design/uart_strobe_sync.sv
// serial byte strobe sampler

module uart_strobe_sync
    import loader_pkg::*;
(
    input  logic  i_clk_rd,
    input  logic  i_rst_n,
    input  logic  i_clk_wr,
    input  logic  i_valid_uart,
    input  byte_t i_data_uart,
    output logic  o_byte_valid,
    output byte_t o_byte
);

    logic clk_wr_s1;
    logic clk_wr_s2;
    logic clk_wr_d;
    logic strobe_fall;

    // two-flop sampler, then edge register
    always_ff @(posedge i_clk_rd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_wr_s1 <= 1'b0;
            clk_wr_s2 <= 1'b0;
            clk_wr_d  <= 1'b0;
        end else begin
            clk_wr_s1 <= i_clk_wr;
            clk_wr_s2 <= clk_wr_s1;
            clk_wr_d  <= clk_wr_s2;
        end
    end

    assign strobe_fall = clk_wr_d && !clk_wr_s2;

    // data is held across the whole strobe, so no sync needed
    always_ff @(posedge i_clk_rd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= strobe_fall && i_valid_uart;
        end
    end

    always_ff @(posedge i_clk_rd) begin
        if (strobe_fall && i_valid_uart) begin
            o_byte <= i_data_uart;
        end
    end

    // one push per strobe period
    a_single_pulse: assert property (@(posedge i_clk_rd) disable iff (!i_rst_n)
        o_byte_valid |=> !o_byte_valid);

endmodule

// File: design/word_assembler.sv
// byte pair to instruction word

`include "loader_defs.svh"

module word_assembler
    import loader_pkg::*;
(
    input  logic                       i_clk_rd,
    input  logic                       i_rst_n,
    input  logic                       i_load_en,
    input  logic                       i_fifo_empty,
    input  byte_t                      i_fifo_data,
    output logic                       o_pop,
    output logic                       o_wr_en,
    output logic [`LOADER_PMEM_AW-1:0] o_wr_addr,
    output instr_word_u                o_wr_word
);

    logic  half_full;
    byte_t opcode_q;

    // one byte per cycle while enabled
    assign o_pop = i_load_en && !i_fifo_empty;

    always_ff @(posedge i_clk_rd or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_full <= 1'b0;
            o_wr_en   <= 1'b0;
            o_wr_addr <= '0;
        end else begin
            o_wr_en <= o_pop && half_full;
            if (o_pop) begin
                half_full <= !half_full;
            end
            // advance once the word has been written, wraps at 256
            if (o_wr_en) begin
                o_wr_addr <= o_wr_addr + 1'b1;
            end
        end
    end

    // first byte waits here for its operand
    always_ff @(posedge i_clk_rd) begin
        if (o_pop && !half_full) begin
            opcode_q <= i_fifo_data;
        end
        if (o_pop && half_full) begin
            o_wr_word.fields.opcode  <= opcode_q;
            o_wr_word.fields.operand <= i_fifo_data;
        end
    end

    // pairs take two pops, so writes are spaced
    a_wr_spaced: assert property (@(posedge i_clk_rd) disable iff (!i_rst_n)
        o_wr_en |=> !o_wr_en);

endmodule

// File: sim.f
+incdir+design
design/loader_pkg.sv
design/uart_strobe_sync.sv
design/byte_fifo.sv
design/word_assembler.sv
design/program_mem.sv
design/loader_top.sv
tests/loader_tb.sv

// File: tests/loader_tb.sv
// program loader testbench

module loader_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // bytes driven over all tests including the 5 gating strobes
    localparam int TOTAL_BYTES = 75;
    localparam int FIFO_DEPTH  = 16;

    logic       i_clk_rd;
    logic       i_rst_n;
    logic       i_clk_wr;
    logic       i_valid_uart;
    logic [7:0] i_data_uart;
    logic       i_load_en;
    logic [7:0] i_cpu_addr;
    logic [7:0] o_opcode;
    logic [7:0] o_operand;
    logic [7:0] o_load_addr;
    logic       o_fifo_empty;
    logic       o_fifo_full;

    int          error_count;
    int          check_count;
    logic [31:0] rng_state;
    // accepted bytes not yet paired into a word
    logic [7:0]  pending_q[$];
    logic [15:0] exp_mem [256];
    logic [7:0]  exp_addr;

    loader_top loader_top_i (.*);

    initial begin
        i_clk_rd = 1'b0;
        forever #50 i_clk_rd = ~i_clk_rd;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic next_cycle();
        @(posedge i_clk_rd);
        #10;
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED: %s actual 0x%0h expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one strobe period of 4 cycles high and 4 low
    task automatic strobe_period(input logic valid);
        i_valid_uart = valid;
        i_clk_wr     = 1'b1;
        repeat (4) next_cycle();
        i_clk_wr = 1'b0;
        repeat (4) next_cycle();
    endtask

    task automatic send_byte(input logic [7:0] data, input logic accepted);
        i_data_uart = data;
        strobe_period(1'b1);
        if (accepted) begin
            pending_q.push_back(data);
        end
    endtask

    task automatic wait_drain();
        int quiet;
        quiet = 0;
        while (quiet < 6) begin
            next_cycle();
            quiet = o_fifo_empty ? quiet + 1 : 0;
        end
    endtask

    // pair bytes in arrival order and leave an odd byte queued
    task automatic build_expected_words();
        logic [7:0] opcode;
        logic [7:0] operand;
        while (pending_q.size() >= 2) begin
            opcode  = pending_q.pop_front();
            operand = pending_q.pop_front();
            exp_mem[exp_addr] = {opcode, operand};
            exp_addr = exp_addr + 8'd1;
        end
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [7:0] opcode,
                             output logic [7:0] operand);
        i_cpu_addr = addr;
        next_cycle();
        opcode  = o_opcode;
        operand = o_operand;
    endtask

    task automatic check_words(input logic [7:0] first, input int count);
        logic [7:0] opcode;
        logic [7:0] operand;
        logic [7:0] addr;
        int         i;
        for (i = 0; i < count; i++) begin
            addr = first + i[7:0];
            read_word(addr, opcode, operand);
            check_value($sformatf("o_opcode[%0d]", addr), opcode, exp_mem[addr][15:8]);
            check_value($sformatf("o_operand[%0d]", addr), operand, exp_mem[addr][7:0]);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_reset_state();
        check_value("o_fifo_empty", o_fifo_empty, 1'b1);
        check_value("o_fifo_full", o_fifo_full, 1'b0);
        check_value("o_load_addr", o_load_addr, 8'h00);
    endtask

    task automatic test_pairing();
        logic [7:0] first;
        int         i;
        first = exp_addr;
        for (i = 0; i < 6; i++) begin
            send_byte(8'ha0 + i[7:0], 1'b1);
        end
        wait_drain();
        build_expected_words();
        check_value("o_load_addr", o_load_addr, first + 8'd3);
        check_words(first, 3);
    endtask

    task automatic test_odd_byte();
        logic [7:0] first;
        int         i;
        first = exp_addr;
        for (i = 0; i < 3; i++) begin
            send_byte(8'h51 + i[7:0], 1'b1);
        end
        wait_drain();
        build_expected_words();
        check_value("o_load_addr", o_load_addr, first + 8'd1);
        send_byte(8'h5f, 1'b1);
        wait_drain();
        build_expected_words();
        check_value("o_load_addr", o_load_addr, first + 8'd2);
        check_words(first, 2);
    endtask

    task automatic test_overflow();
        logic [7:0] first;
        int         i;
        first = exp_addr;
        i_load_en = 1'b0;
        // only the first FIFO_DEPTH bytes fit
        for (i = 0; i < 20; i++) begin
            send_byte(8'hc0 + i[7:0], i < FIFO_DEPTH);
        end
        check_value("o_fifo_full", o_fifo_full, 1'b1);
        check_value("o_load_addr", o_load_addr, first);
        i_load_en = 1'b1;
        wait_drain();
        build_expected_words();
        check_value("o_load_addr", o_load_addr, first + 8'd8);
        check_value("o_fifo_full", o_fifo_full, 1'b0);
        check_words(first, 8);
    endtask

    task automatic test_valid_gating();
        i_data_uart = 8'hee;
        repeat (5) begin
            strobe_period(1'b0);
        end
        // a stray push would show up here
        repeat (4) begin
            next_cycle();
            check_value("o_fifo_empty", o_fifo_empty, 1'b1);
        end
        check_value("o_load_addr", o_load_addr, exp_addr);
    endtask

    task automatic test_random_stream();
        logic [7:0] first;
        int         i;
        first = exp_addr;
        for (i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            send_byte(rng_state[7:0], 1'b1);
        end
        wait_drain();
        build_expected_words();
        check_value("o_load_addr", o_load_addr, first + 8'd20);
        check_words(first, 20);
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        rng_state    = 32'ha604_81b6;
        exp_addr     = 8'h00;
        i_rst_n      = 1'b0;
        i_clk_wr     = 1'b0;
        i_valid_uart = 1'b0;
        i_data_uart  = 8'h00;
        i_load_en    = 1'b1;
        i_cpu_addr   = 8'h00;
        repeat (2) next_cycle();
        i_rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_pairing();
        test_odd_byte();
        test_overflow();
        test_valid_gating();
        test_random_stream();
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog scaled at 12 cycles per byte plus margin
    initial begin
        #(TOTAL_BYTES * 12 * 100 + 50_000);
        $display("timeout: tests did not finish in time, errors so far: %0d", error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule
